// ==== verification/program_trace.txt ====
# P word | T test count | C kind(R reg, S store) rd address(pc or store addr) data, hex
P 00500093
P FFD00113
P 002081B3
P 40208233
P 401152B3
P 00112333
P 001133B3
P 0F00C413
P 00309493
P 01C15513
P 009465B3
P 00A5F633
P 00160693
P 00C68733
P 00D707B3
P 00D78833
P 10000893
P 12345937
P 67890913
P 0128A023
P F8000993
P 013880A3
P 00089A03
P 0008DA83
P 00188B03
P 0018CB83
P 00189123
P 0008AC83
P 001C8D33
P 0008AD83
P 41AD8E33
P 00108463
P 00100E93
P 00109463
P 00114463
P 00200E93
P 0020D463
P 00300E93
P 0020E463
P 00400E93
P 0020F463
P 0020C463
P 00C00F6F
P 00500E93
P 00600E93
P 00001F97
P 0C800293
P 00028367
P 00700E93
P 00800E93
P 009E8E93
P 03700013
P 001003B3
P 0000006F
P 00000013
P 00000013
P 00000013
P 00000013
T arith 12
T forward 4
T memory 12
T loaduse 3
T control 5
T zero 1
C R 1 00000000 00000005
C R 2 00000004 FFFFFFFD
C R 3 00000008 00000002
C R 4 0000000C 00000008
C R 5 00000010 FFFFFFFF
C R 6 00000014 00000001
C R 7 00000018 00000000
C R 8 0000001C 000000F5
C R 9 00000020 00000028
C R 10 00000024 0000000F
C R 11 00000028 000000FD
C R 12 0000002C 0000000D
C R 13 00000030 0000000E
C R 14 00000034 0000001B
C R 15 00000038 00000029
C R 16 0000003C 00000037
C R 17 00000040 00000100
C R 18 00000044 12345000
C R 18 00000048 12345678
C S 0 00000100 12345678
C R 19 00000050 FFFFFF80
C S 0 00000101 00000080
C R 20 00000058 FFFF8078
C R 21 0000005C 00008078
C R 22 00000060 FFFFFF80
C R 23 00000064 00000080
C S 0 00000102 00000005
C R 25 0000006C 00058078
C R 26 00000070 0005807D
C R 27 00000074 00058078
C R 28 00000078 FFFFFFFB
C R 30 000000A8 000000AC
C R 31 000000B4 000010B4
C R 5 000000B8 000000C8
C R 6 000000BC 000000C0
C R 29 000000C8 00000009
C R 7 000000D0 00000005

// ==== verilog.f ====
source/rvCorePkg.sv
source/controlMain.sv
source/hazardUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/dataMemory.sv
source/pipelineCore.sv
verification/clockGen.sv
verification/commitMonitor.sv
verification/core_checker.sv
verification/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  logic clock;
  logic genReset;
  logic loadReset;
  logic reset;
  logic imemWriteEnable;
  rvCorePkg::wordT imemWriteAddress;
  rvCorePkg::instrT imemWriteData;
  rvCorePkg::commitT commit;
  logic done;
  int passCount;
  int failCount;
  int strayCount;
  rvCorePkg::instrT programWords[$];
  int expectedTotal;
  logic finished;
  logic traceOk;
  int unsigned gap;

  assign reset = genReset || loadReset; // held on until the program is in

  clockGen clockGen0
  (
    .clock(clock),
    .reset(genReset)
  );

  pipelineCore dut0
  (
    .clock(clock),
    .reset(reset),
    .imemWriteEnable(imemWriteEnable),
    .imemWriteAddress(imemWriteAddress),
    .imemWriteData(imemWriteData),
    .commit(commit)
  );

  commitMonitor monitor0
  (
    .clock(clock),
    .reset(reset),
    .commit(commit),
    .done(done),
    .passCount(passCount),
    .failCount(failCount),
    .strayCount(strayCount)
  );

  task automatic readTrace(output logic ok);
    int fd;
    int count;
    int rd;
    string line;
    string name;
    string kind;
    rvCorePkg::wordT word;
    rvCorePkg::wordT address;
    rvCorePkg::wordT data;
    ok = 1'b0;
    expectedTotal = 0;
    fd = $fopen("verification/program_trace.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.substr(0, 0) == "#")
          continue; // blank or comment
        if (line.substr(0, 0) == "P")
        begin
          void'($sscanf(line, "P %h", word));
          programWords.push_back(word);
        end
        else if (line.substr(0, 0) == "T")
        begin
          void'($sscanf(line, "T %s %d", name, count));
          monitor0.addTest(name, count);
        end
        else if (line.substr(0, 0) == "C")
        begin
          void'($sscanf(line, "C %s %d %h %h", kind, rd, address, data));
          monitor0.addCommit(kind == "S", rd, address, data);
          expectedTotal++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic loadProgram();
    for (int i = 0; i < programWords.size(); i++)
    begin
      @(posedge clock);
      imemWriteEnable <= 1'b1;
      imemWriteAddress <= rvCorePkg::wordT'(i * 4);
      imemWriteData <= programWords[i];
    end
    @(posedge clock);
    imemWriteEnable <= 1'b0;
  endtask

  initial
  begin
    imemWriteEnable = 1'b0;
    imemWriteAddress = '0;
    imemWriteData = '0;
    loadReset = 1'b1;
    finished = 1'b0;
    gap = $urandom(25404);
    readTrace(traceOk);
    if (!traceOk)
    begin
      $display("could not open the trace file verification/program_trace.txt");
      $display("Simulation FAILED");
      $finish;
    end
    else
    begin
      loadProgram();
      gap = $urandom % 8; // idle cycles before release
      repeat (gap) @(posedge clock);
      wait (!genReset);
      @(posedge clock);
      loadReset <= 1'b0;
      wait (done);
      finished = 1'b1;
      repeat (20) @(posedge clock); // catch stray commits
      $display("tests passed %0d failed %0d, stray commits %0d, assertion failures %0d",
               passCount, failCount, strayCount, dut0.checker0.failures);
      if (failCount == 0 && strayCount == 0 && dut0.checker0.failures == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
      $finish;
    end
  end

  // limit scales with the expected commit count
  initial
  begin
    wait (reset === 1'b0);
    repeat (8 * expectedTotal + 100) @(posedge clock);
    if (!finished)
    begin
      $display("commits stopped arriving before all expected commits were seen");
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreChecker
(
  input  logic clock,
  input  logic reset,
  input  rvCorePkg::commitT commit,
  input  logic ifIdValid,
  input  rvCorePkg::wordT ifIdPc,
  input  logic idExValid,
  input  rvCorePkg::wordT idExPc,
  input  logic exMemValid,
  input  rvCorePkg::wordT exMemPc
);

  int failures = 0;

  quietInReset: assert property (@(posedge clock) reset && $past(reset) |-> !commit.valid)
    else
    begin
      failures++;
      $error("commit valid while reset held");
    end

  // stage valid implies a known pc
  knownPc: assert property (@(posedge clock) disable iff (reset)
    (ifIdValid |-> !$isunknown(ifIdPc)) and (idExValid |-> !$isunknown(idExPc))
    and (exMemValid |-> !$isunknown(exMemPc)))
    else
    begin
      failures++;
      $error("valid stage holds an unknown pc");
    end

  noZeroWrite: assert property (@(posedge clock) disable iff (reset)
    commit.valid && !commit.isStore |-> commit.rd != '0)
    else
    begin
      failures++;
      $error("register commit names x0");
    end

endmodule

bind pipelineCore coreChecker checker0
(
  .clock(clock),
  .reset(reset),
  .commit(commit),
  .ifIdValid(ifId.valid),
  .ifIdPc(ifId.pc),
  .idExValid(idEx.valid),
  .idExPc(idEx.pc),
  .exMemValid(exMem.valid),
  .exMemPc(exMem.pc)
);

`default_nettype wire

// ==== verification/commitMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module commitMonitor
(
  input  logic clock,
  input  logic reset,
  input  rvCorePkg::commitT commit,
  output logic done,
  output int passCount,
  output int failCount,
  output int strayCount
);

  string testNames[$];
  int testSizes[$];
  rvCorePkg::commitT expected[$];
  int entryIndex;
  int testIndex;
  int countInTest;
  logic testFailed;

  initial
  begin
    done = 1'b0;
    passCount = 0;
    failCount = 0;
    strayCount = 0;
    entryIndex = 0;
    testIndex = 0;
    countInTest = 0;
    testFailed = 1'b0;
  end

  task automatic addTest(input string name, input int size);
    testNames.push_back(name);
    testSizes.push_back(size);
  endtask

  task automatic addCommit(input logic isStore, input int rd, input rvCorePkg::wordT address,
                           input rvCorePkg::wordT data);
    rvCorePkg::commitT entry;
    entry = '0;
    entry.valid = 1'b1;
    entry.isStore = isStore;
    entry.rd = rvCorePkg::regIndexT'(rd);
    entry.address = address;
    entry.data = data;
    expected.push_back(entry);
  endtask

  function automatic string describeCommit(input rvCorePkg::commitT entry);
    return $sformatf("store=%0b rd=%0d addr=%h data=%h", entry.isStore, entry.rd,
                     entry.address, entry.data);
  endfunction

  always @(posedge clock)
  begin
    if (!reset && commit.valid)
    begin
      if (entryIndex >= expected.size() || testIndex >= testNames.size())
      begin
        strayCount++;
        $display("unexpected commit after the last expected one: %s",
                 describeCommit(commit));
      end
      else
      begin
        if (commit !== expected[entryIndex])
        begin
          testFailed = 1'b1;
          $display("Error test %s entry %0d expected %s actual %s",
                   testNames[testIndex], countInTest,
                   describeCommit(expected[entryIndex]), describeCommit(commit));
        end
        entryIndex++;
        countInTest++;
        if (countInTest == testSizes[testIndex])
        begin
          if (testFailed)
            failCount++;
          else
            passCount++;
          $display("test %s %s after %0d commits", testNames[testIndex],
                   testFailed ? "failed" : "ok", countInTest);
          testIndex++;
          countInTest = 0;
          testFailed = 1'b0;
          if (testIndex == testNames.size())
            done = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/pipelineCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCore
(
  input  logic clock,
  input  logic reset,
  input  logic imemWriteEnable,
  input  rvCorePkg::wordT imemWriteAddress,
  input  rvCorePkg::instrT imemWriteData,
  output rvCorePkg::commitT commit
);

  rvCorePkg::instrT imem [2**rvCorePkg::imemDepthLog2];
  rvCorePkg::wordT pc;
  rvCorePkg::ifIdT ifId;
  rvCorePkg::idExT idEx;
  rvCorePkg::exMemT exMem;
  rvCorePkg::memWbT memWb;

  rvCorePkg::ctrlT idCtrl;
  rvCorePkg::wordT idImm;
  rvCorePkg::wordT idRs1Data;
  rvCorePkg::wordT idRs2Data;
  logic stall;
  logic flush;
  logic redirect;
  rvCorePkg::forwardT forwardA;
  rvCorePkg::forwardT forwardB;

  rvCorePkg::wordT operandA;
  rvCorePkg::wordT operandB;
  rvCorePkg::wordT aluResult;
  rvCorePkg::wordT exTarget;
  logic aluZero;
  logic aluLess;

  rvCorePkg::wordT memLinkResult;
  rvCorePkg::wordT memResult;
  rvCorePkg::wordT loadData;
  rvCorePkg::wordT storeBytes;
  logic branchTaken;

  rvCorePkg::commitT wbRecord;
  rvCorePkg::commitT storeRecord;
  rvCorePkg::commitT storeHold; // store delayed behind a register commit
  logic wbCommit;
  logic storeInMem;

  always_ff @(posedge clock)
  begin
    if (imemWriteEnable)
      imem[imemWriteAddress[rvCorePkg::imemDepthLog2+1:2]] <= imemWriteData;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;
    else if (redirect)
      pc <= exMem.target;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clock)
  begin
    if (reset || flush)
      ifId <= '0;
    else if (!stall)
    begin
      ifId.valid <= 1'b1;
      ifId.pc <= pc;
      ifId.instr <= imem[pc[rvCorePkg::imemDepthLog2+1:2]];
    end
  end

  controlMain control0
  (
    .instruction(ifId.instr),
    .control(idCtrl),
    .immediate(idImm)
  );

  registerFile regFile0
  (
    .clock(clock),
    .reset(reset),
    .readIndexA(ifId.instr[19:15]),
    .readIndexB(ifId.instr[24:20]),
    .readDataA(idRs1Data),
    .readDataB(idRs2Data),
    .writeEnable(memWb.valid && memWb.ctrl.regWrite),
    .writeIndex(memWb.rd),
    .writeData(memWb.result)
  );

  hazardUnit hazard0
  (
    .idRs1(ifId.instr[19:15]),
    .idRs2(ifId.instr[24:20]),
    .exRd(idEx.rd),
    .exMemRead(idEx.ctrl.memRead),
    .memRd(exMem.rd),
    .wbRd(memWb.rd),
    .memRegWrite(exMem.ctrl.regWrite),
    .wbRegWrite(memWb.ctrl.regWrite),
    .exRs1(idEx.rs1),
    .exRs2(idEx.rs2),
    .redirect(redirect),
    .stall(stall),
    .flush(flush),
    .forwardA(forwardA),
    .forwardB(forwardB)
  );

  always_ff @(posedge clock)
  begin
    if (reset || flush || stall)
      idEx <= '0; // bubble
    else
    begin
      idEx.valid <= ifId.valid;
      idEx.pc <= ifId.pc;
      idEx.rs1 <= ifId.instr[19:15];
      idEx.rs2 <= ifId.instr[24:20];
      idEx.rd <= ifId.instr[11:7];
      idEx.rs1Data <= idRs1Data;
      idEx.rs2Data <= idRs2Data;
      idEx.imm <= idImm;
      idEx.ctrl <= idCtrl;
    end
  end

  always_comb
  begin
    case (forwardA)
      rvCorePkg::fwdMem: operandA = memLinkResult;
      rvCorePkg::fwdWb: operandA = memWb.result;
      default: operandA = idEx.rs1Data;
    endcase
    case (forwardB)
      rvCorePkg::fwdMem: operandB = memLinkResult;
      rvCorePkg::fwdWb: operandB = memWb.result;
      default: operandB = idEx.rs2Data;
    endcase
  end

  aluUnit alu0
  (
    .operation(idEx.ctrl.aluOp),
    .operandA(operandA),
    .operandB(idEx.ctrl.aluSrc ? idEx.imm : operandB),
    .pc(idEx.pc),
    .result(aluResult),
    .zero(aluZero),
    .less(aluLess)
  );

  // jalr takes rs1+imm from the alu, others are pc relative
  assign exTarget = (idEx.ctrl.jump && idEx.ctrl.aluSrc) ? {aluResult[31:1], 1'b0}
                                                         : idEx.pc + idEx.imm;

  always_ff @(posedge clock)
  begin
    if (reset || flush)
      exMem <= '0;
    else
    begin
      exMem.valid <= idEx.valid;
      exMem.pc <= idEx.pc;
      exMem.rd <= idEx.rd;
      exMem.aluResult <= aluResult;
      exMem.storeData <= operandB;
      exMem.target <= exTarget;
      exMem.zero <= aluZero;
      exMem.less <= aluLess;
      exMem.ctrl <= idEx.ctrl;
    end
  end

  dataMemory dmem0
  (
    .clock(clock),
    .reset(reset),
    .readEnable(exMem.valid && exMem.ctrl.memRead),
    .writeEnable(storeInMem),
    .size(exMem.ctrl.memSize),
    .address(exMem.aluResult),
    .writeData(exMem.storeData),
    .readData(loadData)
  );

  always_comb
  begin
    case (exMem.ctrl.memSize)
      rvCorePkg::funct3Beq: branchTaken = exMem.zero;
      rvCorePkg::funct3Bne: branchTaken = !exMem.zero;
      rvCorePkg::funct3Blt, rvCorePkg::funct3Bltu: branchTaken = exMem.less;
      rvCorePkg::funct3Bge, rvCorePkg::funct3Bgeu: branchTaken = !exMem.less;
      default: branchTaken = 1'b0;
    endcase
  end

  assign redirect = exMem.valid && (exMem.ctrl.jump || (exMem.ctrl.branch && branchTaken));
  assign memLinkResult = exMem.ctrl.linkPc ? exMem.pc + 32'd4 : exMem.aluResult;
  assign memResult = exMem.ctrl.memToReg ? loadData : memLinkResult;

  always_ff @(posedge clock)
  begin
    if (reset)
      memWb <= '0;
    else
    begin
      memWb.valid <= exMem.valid;
      memWb.pc <= exMem.pc;
      memWb.rd <= exMem.rd;
      memWb.result <= memResult;
      memWb.ctrl <= exMem.ctrl;
    end
  end

  assign wbCommit = memWb.valid && memWb.ctrl.regWrite && (memWb.rd != '0);
  assign storeInMem = exMem.valid && exMem.ctrl.memWrite;

  always_comb
  begin
    case (exMem.ctrl.memSize)
      rvCorePkg::funct3Sb: storeBytes = {24'b0, exMem.storeData[7:0]};
      rvCorePkg::funct3Sh: storeBytes = {16'b0, exMem.storeData[15:0]};
      default: storeBytes = exMem.storeData;
    endcase
  end

  always_comb
  begin
    wbRecord = '0;
    wbRecord.valid = 1'b1;
    wbRecord.rd = memWb.rd;
    wbRecord.address = memWb.pc;
    wbRecord.data = memWb.result;
    storeRecord = '0;
    storeRecord.valid = 1'b1;
    storeRecord.isStore = 1'b1;
    storeRecord.address = exMem.aluResult;
    storeRecord.data = storeBytes;
  end

  // a held store sits in WB next cycle, so it never meets a register commit
  always_ff @(posedge clock)
  begin
    if (reset)
      storeHold <= '0;
    else if (storeInMem && (wbCommit || storeHold.valid))
      storeHold <= storeRecord;
    else
      storeHold <= '0;
  end

  always_comb
  begin
    if (wbCommit)
      commit = wbRecord;
    else if (storeHold.valid)
      commit = storeHold;
    else if (storeInMem)
      commit = storeRecord;
    else
      commit = '0;
  end

endmodule

`default_nettype wire

// ==== source/dataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMemory
(
  input  logic clock,
  input  logic reset,
  input  logic readEnable,
  input  logic writeEnable,
  input  logic [2:0] size,
  input  rvCorePkg::wordT address,
  input  rvCorePkg::wordT writeData,
  output rvCorePkg::wordT readData
);

  logic [7:0] bytes [2**rvCorePkg::dmemDepthLog2];
  logic [rvCorePkg::dmemDepthLog2-1:0] addr0;
  logic [rvCorePkg::dmemDepthLog2-1:0] addr1;
  logic [rvCorePkg::dmemDepthLog2-1:0] addr2;
  logic [rvCorePkg::dmemDepthLog2-1:0] addr3;
  rvCorePkg::wordT rawWord;

  // addresses wrap around the array
  assign addr0 = address[rvCorePkg::dmemDepthLog2-1:0];
  assign addr1 = addr0 + 1'b1;
  assign addr2 = addr0 + 2'd2;
  assign addr3 = addr0 + 2'd3;

  always_ff @(posedge clock)
  begin
    if (writeEnable && !reset)
    begin
      case (size)
        rvCorePkg::funct3Sb: bytes[addr0] <= writeData[7:0];
        rvCorePkg::funct3Sh:
        begin
          bytes[addr0] <= writeData[7:0];
          bytes[addr1] <= writeData[15:8];
        end
        rvCorePkg::funct3Sw:
        begin
          bytes[addr0] <= writeData[7:0];
          bytes[addr1] <= writeData[15:8];
          bytes[addr2] <= writeData[23:16];
          bytes[addr3] <= writeData[31:24];
        end
        default: ; // undefined store size writes nothing
      endcase
    end
  end

  assign rawWord = {bytes[addr3], bytes[addr2], bytes[addr1], bytes[addr0]};

  always_comb
  begin
    readData = '0;
    if (readEnable)
    begin
      case (size)
        rvCorePkg::funct3Lb: readData = {{24{rawWord[7]}}, rawWord[7:0]};
        rvCorePkg::funct3Lh: readData = {{16{rawWord[15]}}, rawWord[15:0]};
        rvCorePkg::funct3Lw: readData = rawWord;
        rvCorePkg::funct3Lbu: readData = {24'b0, rawWord[7:0]};
        rvCorePkg::funct3Lhu: readData = {16'b0, rawWord[15:0]};
        default: readData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit
(
  input  rvCorePkg::aluOpT operation,
  input  rvCorePkg::wordT operandA,
  input  rvCorePkg::wordT operandB,
  input  rvCorePkg::wordT pc,
  output rvCorePkg::wordT result,
  output logic zero,
  output logic less
);

  logic [rvCorePkg::xlen:0] difference; // top bit is the borrow
  logic lessSigned;
  logic lessUnsigned;
  logic [4:0] shamt;

  assign difference = {1'b0, operandA} - {1'b0, operandB};
  assign lessUnsigned = difference[rvCorePkg::xlen];
  assign lessSigned = (operandA[rvCorePkg::xlen-1] != operandB[rvCorePkg::xlen-1]) ?
                      operandA[rvCorePkg::xlen-1] : difference[rvCorePkg::xlen-1];
  assign shamt = operandB[4:0];

  assign zero = (difference[rvCorePkg::xlen-1:0] == '0);
  assign less = (operation == rvCorePkg::aluSltu) ? lessUnsigned : lessSigned;

  always_comb
  begin
    case (operation)
      rvCorePkg::aluAdd: result = operandA + operandB;
      rvCorePkg::aluSub: result = difference[rvCorePkg::xlen-1:0];
      rvCorePkg::aluXor: result = operandA ^ operandB;
      rvCorePkg::aluOr: result = operandA | operandB;
      rvCorePkg::aluAnd: result = operandA & operandB;
      rvCorePkg::aluSll: result = operandA << shamt;
      rvCorePkg::aluSrl: result = operandA >> shamt;
      rvCorePkg::aluSra: result = rvCorePkg::wordT'($signed(operandA) >>> shamt);
      rvCorePkg::aluSlt: result = {{(rvCorePkg::xlen-1){1'b0}}, lessSigned};
      rvCorePkg::aluSltu: result = {{(rvCorePkg::xlen-1){1'b0}}, lessUnsigned};
      rvCorePkg::aluPassB: result = operandB; // lui
      rvCorePkg::aluAddPc: result = pc + operandB; // auipc
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
  input  logic clock,
  input  logic reset,
  input  rvCorePkg::regIndexT readIndexA,
  input  rvCorePkg::regIndexT readIndexB,
  output rvCorePkg::wordT readDataA,
  output rvCorePkg::wordT readDataB,
  input  logic writeEnable,
  input  rvCorePkg::regIndexT writeIndex,
  input  rvCorePkg::wordT writeData
);

  rvCorePkg::wordT regs [32];
  logic writeLive;

  assign writeLive = writeEnable && (writeIndex != '0); // x0 stays zero

  always_ff @(posedge clock)
  begin
    if (reset)
      regs <= '{default: '0};
    else if (writeLive)
      regs[writeIndex] <= writeData;
  end

  assign readDataA = (writeLive && writeIndex == readIndexA) ? writeData : regs[readIndexA];
  assign readDataB = (writeLive && writeIndex == readIndexB) ? writeData : regs[readIndexB];

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
(
  input  rvCorePkg::regIndexT idRs1,
  input  rvCorePkg::regIndexT idRs2,
  input  rvCorePkg::regIndexT exRd,
  input  logic exMemRead,
  input  rvCorePkg::regIndexT memRd,
  input  rvCorePkg::regIndexT wbRd,
  input  logic memRegWrite,
  input  logic wbRegWrite,
  input  rvCorePkg::regIndexT exRs1,
  input  rvCorePkg::regIndexT exRs2,
  input  logic redirect,
  output logic stall,
  output logic flush,
  output rvCorePkg::forwardT forwardA,
  output rvCorePkg::forwardT forwardB
);

  logic memHit;
  logic wbHit;

  assign memHit = memRegWrite && (memRd != '0);
  assign wbHit = wbRegWrite && (wbRd != '0);

  // load in EX, consumer in ID
  assign stall = exMemRead && (exRd != '0) && (exRd == idRs1 || exRd == idRs2);
  assign flush = redirect;

  always_comb
  begin
    forwardA = rvCorePkg::fwdNone;
    forwardB = rvCorePkg::fwdNone;
    if (memHit && memRd == exRs1)
      forwardA = rvCorePkg::fwdMem; // youngest value wins
    else if (wbHit && wbRd == exRs1)
      forwardA = rvCorePkg::fwdWb;
    if (memHit && memRd == exRs2)
      forwardB = rvCorePkg::fwdMem;
    else if (wbHit && wbRd == exRs2)
      forwardB = rvCorePkg::fwdWb;
  end

endmodule

`default_nettype wire

// ==== source/controlMain.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlMain
(
  input  rvCorePkg::instrT instruction,
  output rvCorePkg::ctrlT control,
  output rvCorePkg::wordT immediate
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic altFunct;
  rvCorePkg::aluOpT arithOp;
  rvCorePkg::aluOpT branchOp;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign altFunct = instruction[30]; // funct7 bit for sub and sra

  always_comb
  begin
    case (funct3)
      rvCorePkg::funct3AddSub:
        arithOp = (altFunct && opcode == rvCorePkg::opR) ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
      rvCorePkg::funct3Sll: arithOp = rvCorePkg::aluSll;
      rvCorePkg::funct3Slt: arithOp = rvCorePkg::aluSlt;
      rvCorePkg::funct3Sltu: arithOp = rvCorePkg::aluSltu;
      rvCorePkg::funct3Xor: arithOp = rvCorePkg::aluXor;
      rvCorePkg::funct3SrlSra: arithOp = altFunct ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
      rvCorePkg::funct3Or: arithOp = rvCorePkg::aluOr;
      rvCorePkg::funct3And: arithOp = rvCorePkg::aluAnd;
      default: arithOp = rvCorePkg::aluAdd;
    endcase
  end

  always_comb
  begin
    case (funct3)
      rvCorePkg::funct3Blt, rvCorePkg::funct3Bge: branchOp = rvCorePkg::aluSlt;
      rvCorePkg::funct3Bltu, rvCorePkg::funct3Bgeu: branchOp = rvCorePkg::aluSltu;
      default: branchOp = rvCorePkg::aluSub; // beq, bne
    endcase
  end

  always_comb
  begin
    control = '0;
    control.memSize = funct3;
    case (opcode)
      rvCorePkg::opR:
      begin
        control.regWrite = 1'b1;
        control.aluOp = arithOp;
      end
      rvCorePkg::opImm:
      begin
        control.regWrite = 1'b1;
        control.aluSrc = 1'b1;
        control.aluOp = arithOp;
      end
      rvCorePkg::opLoad:
      begin
        control.regWrite = 1'b1;
        control.memRead = 1'b1;
        control.memToReg = 1'b1;
        control.aluSrc = 1'b1;
      end
      rvCorePkg::opStore:
      begin
        control.memWrite = 1'b1;
        control.aluSrc = 1'b1;
      end
      rvCorePkg::opBranch:
      begin
        control.branch = 1'b1;
        control.aluOp = branchOp;
      end
      rvCorePkg::opJal:
      begin
        control.regWrite = 1'b1;
        control.jump = 1'b1;
        control.linkPc = 1'b1;
      end
      rvCorePkg::opJalr:
      begin
        control.regWrite = 1'b1;
        control.jump = 1'b1;
        control.linkPc = 1'b1;
        control.aluSrc = 1'b1; // alu forms rs1+imm target
      end
      rvCorePkg::opLui:
      begin
        control.regWrite = 1'b1;
        control.aluSrc = 1'b1;
        control.aluOp = rvCorePkg::aluPassB;
      end
      rvCorePkg::opAuipc:
      begin
        control.regWrite = 1'b1;
        control.aluSrc = 1'b1;
        control.aluOp = rvCorePkg::aluAddPc;
      end
      default: control = '0;
    endcase
  end

  always_comb
  begin
    case (opcode)
      rvCorePkg::opStore:
        immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      rvCorePkg::opBranch:
        immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      rvCorePkg::opJal:
        immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                     instruction[20], instruction[30:21], 1'b0};
      rvCorePkg::opLui, rvCorePkg::opAuipc:
        immediate = {instruction[31:12], 12'b0};
      default:
        immediate = {{20{instruction[31]}}, instruction[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// ==== source/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

  localparam int xlen = 32;
  localparam int imemDepthLog2 = 8; // 256 words
  localparam int dmemDepthLog2 = 10; // 1 KiB of bytes

  typedef logic [xlen-1:0] wordT;
  typedef logic [4:0] regIndexT;
  typedef logic [31:0] instrT;

  localparam logic [6:0] opR = 7'b0110011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;

  localparam logic [2:0] funct3AddSub = 3'b000;
  localparam logic [2:0] funct3Sll = 3'b001;
  localparam logic [2:0] funct3Slt = 3'b010;
  localparam logic [2:0] funct3Sltu = 3'b011;
  localparam logic [2:0] funct3Xor = 3'b100;
  localparam logic [2:0] funct3SrlSra = 3'b101;
  localparam logic [2:0] funct3Or = 3'b110;
  localparam logic [2:0] funct3And = 3'b111;

  localparam logic [2:0] funct3Lb = 3'b000;
  localparam logic [2:0] funct3Lh = 3'b001;
  localparam logic [2:0] funct3Lw = 3'b010;
  localparam logic [2:0] funct3Lbu = 3'b100;
  localparam logic [2:0] funct3Lhu = 3'b101;
  localparam logic [2:0] funct3Sb = 3'b000;
  localparam logic [2:0] funct3Sh = 3'b001;
  localparam logic [2:0] funct3Sw = 3'b010;

  localparam logic [2:0] funct3Beq = 3'b000;
  localparam logic [2:0] funct3Bne = 3'b001;
  localparam logic [2:0] funct3Blt = 3'b100;
  localparam logic [2:0] funct3Bge = 3'b101;
  localparam logic [2:0] funct3Bltu = 3'b110;
  localparam logic [2:0] funct3Bgeu = 3'b111;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluXor, aluOr, aluAnd, aluSll,
    aluSrl, aluSra, aluSlt, aluSltu, aluPassB, aluAddPc
  } aluOpT;

  typedef enum logic [1:0] {
    fwdNone, fwdMem, fwdWb
  } forwardT;

  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic memToReg;
    logic aluSrc;
    logic branch;
    logic jump;
    logic linkPc; // rd gets pc+4
    aluOpT aluOp;
    logic [2:0] memSize; // funct3, also the branch kind
  } ctrlT;

  typedef struct packed {
    logic valid;
    wordT pc;
    instrT instr;
  } ifIdT;

  typedef struct packed {
    logic valid;
    wordT pc;
    regIndexT rs1;
    regIndexT rs2;
    regIndexT rd;
    wordT rs1Data;
    wordT rs2Data;
    wordT imm;
    ctrlT ctrl;
  } idExT;

  typedef struct packed {
    logic valid;
    wordT pc;
    regIndexT rd;
    wordT aluResult;
    wordT storeData;
    wordT target;
    logic zero;
    logic less;
    ctrlT ctrl;
  } exMemT;

  typedef struct packed {
    logic valid;
    wordT pc;
    regIndexT rd;
    wordT result;
    ctrlT ctrl;
  } memWbT;

  typedef struct packed {
    logic valid;
    logic isStore;
    regIndexT rd;
    wordT address;
    wordT data;
  } commitT;

endpackage

`default_nettype wire
